/* src.f */
design/jtag_pkg.sv
design/jtag_scan_chain.sv
design/jtag_tap_fsm.sv
design/jtag_ir_decode.sv
design/jtag_data_regs.sv
design/jtag_tdo_result.sv
design/jtag_top.sv
dv/tb_clk_gen.sv
dv/jtag_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the JTAG TAP testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -f src.f --top-module jtag_tb -o jtag_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/jtag_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

exit 0

/* dv/jtag_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_tb;

  localparam int          CLK_PERIOD_NS  = 4;
  localparam logic [31:0] EXP_IDCODE     = 32'h7761_7601;
  localparam logic [7:0]  OP_BYPASS      = 8'hFF;
  localparam logic [7:0]  OP_SCAN_CTRL   = 8'h39;
  localparam logic [7:0]  OP_INT_DSR     = 8'h40;
  localparam logic [7:0]  OP_UNLISTED    = 8'h22;
  localparam logic [7:0]  IR_CAPTURE_VAL = 8'h01;

  // Reset, then tests 1 to 6 in TCK cycles
  localparam int CYCLE_BUDGET = 20 + 50 + 70 + 70 + 320 + 50 + 110;

  logic        tck;
  logic        gen_trst_n;
  logic        trst_pulse_n;
  logic        dut_trst_n;
  logic        tms;
  logic        tdi;
  logic        tdo;
  logic        freeze_n;
  logic        highz_n;
  logic        iddq_mode;
  logic        freeze_n_out;
  logic        highz_n_out;
  logic        iddq_out;
  logic [7:0]  scan_freq_en;
  logic        scan_cgc;
  logic        scan_rst;
  logic        scan_set;
  logic [31:0] rng_state;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(5)) u_clk_gen (
    .o_tck    (tck),
    .o_trst_n (gen_trst_n)
  );

  // Generator reset combined with the pulse used in test 6
  assign dut_trst_n = gen_trst_n & trst_pulse_n;

  jtag_top DUT (
    .i_tck           (tck),
    .i_trst_n        (dut_trst_n),
    .i_tms           (tms),
    .i_tdi           (tdi),
    .o_tdo           (tdo),
    .i_freeze_n      (freeze_n),
    .i_highz_n       (highz_n),
    .i_iddq_mode     (iddq_mode),
    .o_freeze_n      (freeze_n_out),
    .o_highz_n       (highz_n_out),
    .o_iddq_mode     (iddq_out),
    .o_scan_freq_en  (scan_freq_en),
    .o_scan_cgc_ctrl (scan_cgc),
    .o_scan_rst_ctrl (scan_rst),
    .o_scan_set_ctrl (scan_set)
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check(input string test_name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      $display("ERROR: %s expected 0x%0h actual 0x%0h", test_name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Mismatch in %s", test_name);
    end
  endtask

  // Values take effect at the following rising edge
  task automatic step(input logic tms_val, input logic tdi_val);
    @(posedge tck);
    tms <= tms_val;
    tdi <= tdi_val;
  endtask

  // Starts and ends with the TAP headed for Run-Test/Idle
  task automatic scan(input logic is_ir, input int len, input logic [63:0] tdi_bits,
                      output logic [63:0] tdo_bits);
    tdo_bits = '0;
    step(1'b1, 1'b0);
    if (is_ir) begin
      step(1'b1, 1'b0);
    end
    step(1'b0, 1'b0);
    step(1'b0, 1'b0);
    for (int i = 0; i < len; i++) begin
      step(i == len - 1, tdi_bits[i]);
      @(negedge tck);
      #1;
      tdo_bits[i] = tdo;
    end
    step(1'b1, 1'b0);
    step(1'b0, 1'b0);
  endtask

  task automatic load_instruction(input string test_name, input logic [7:0] opcode);
    logic [63:0] tdo_bits;
    scan(1'b1, 8, 64'(opcode), tdo_bits);
    check({test_name, "_ir_capture"}, 64'(IR_CAPTURE_VAL), 64'(tdo_bits[7:0]));
  endtask

  // Bypass echoes TDI one bit late behind a captured 0
  task automatic check_bypass(input string test_name);
    logic [15:0] data;
    logic [63:0] tdo_bits;
    data = 16'(next_random());
    scan(1'b0, 16, 64'(data), tdo_bits);
    check(test_name, 64'({data[14:0], 1'b0}), 64'(tdo_bits[15:0]));
  endtask

  task automatic set_levels(input logic [2:0] levels);
    @(posedge tck);
    freeze_n  <= levels[2];
    highz_n   <= levels[1];
    iddq_mode <= levels[0];
    @(negedge tck);
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_idcode_after_reset();
    logic [63:0] tdo_bits;
    scan(1'b0, 32, 64'(next_random()), tdo_bits);
    check("idcode_after_reset", 64'(EXP_IDCODE), 64'(tdo_bits[31:0]));
  endtask

  task automatic test_bypass();
    load_instruction("bypass", OP_BYPASS);
    check_bypass("bypass_echo");
  endtask

  task automatic test_scan_ctrl();
    logic [11:0] first;
    logic [11:0] second;
    logic [63:0] tdo_bits;
    load_instruction("scan_ctrl", OP_SCAN_CTRL);
    first  = 12'(next_random());
    second = 12'(next_random());
    scan(1'b0, 12, 64'(first), tdo_bits);
    check("scan_ctrl_initial", 64'(12'h000), 64'(tdo_bits[11:0]));
    step(1'b0, 1'b0);
    @(negedge tck);
    check("scan_ctrl_outputs", 64'(first[10:0]),
          64'({scan_set, scan_rst, scan_cgc, scan_freq_en}));
    scan(1'b0, 12, 64'(second), tdo_bits);
    check("scan_ctrl_readback", 64'(first), 64'(tdo_bits[11:0]));
    step(1'b0, 1'b0);
    @(negedge tck);
    check("scan_ctrl_outputs_2", 64'(second[10:0]),
          64'({scan_set, scan_rst, scan_cgc, scan_freq_en}));
  endtask

  task automatic test_int_dsr();
    logic [3:0]  dsr;
    logic [3:0]  held;
    logic [2:0]  levels;
    logic [63:0] tdo_bits;
    load_instruction("int_dsr", OP_INT_DSR);
    held = 4'h0;
    // Test mode clear, override bits random
    dsr = 4'(next_random()) & 4'hE;
    scan(1'b0, 4, 64'(dsr), tdo_bits);
    check("int_dsr_readback", 64'(held), 64'(tdo_bits[3:0]));
    held = dsr;
    for (int c = 0; c < 8; c++) begin
      levels = 3'(c);
      set_levels(levels);
      check("int_dsr_pass", 64'(levels), 64'({freeze_n_out, highz_n_out, iddq_out}));
    end
    for (int k = 0; k < 4; k++) begin
      dsr = 4'(next_random()) | 4'h1;
      scan(1'b0, 4, 64'(dsr), tdo_bits);
      check("int_dsr_readback", 64'(held), 64'(tdo_bits[3:0]));
      held = dsr;
      for (int c = 0; c < 8; c++) begin
        levels = 3'(c);
        set_levels(levels);
        check("int_dsr_override", 64'({~dsr[1], ~dsr[2], dsr[3]}),
              64'({freeze_n_out, highz_n_out, iddq_out}));
      end
    end
  endtask

  task automatic test_unlisted_opcode();
    load_instruction("unlisted", OP_UNLISTED);
    check_bypass("unlisted_bypass");
  endtask

  task automatic test_reset_paths();
    logic [11:0] value;
    logic [63:0] tdo_bits;
    // Abandon a DR scan in Shift-DR
    step(1'b1, 1'b0);
    step(1'b0, 1'b0);
    step(1'b0, 1'b0);
    step(1'b0, 1'b1);
    step(1'b0, 1'b0);
    repeat (5) step(1'b1, 1'b0);
    step(1'b0, 1'b0);
    // Aligned IR capture shows the TAP passed through Test-Logic-Reset
    load_instruction("tms_reset", OP_SCAN_CTRL);
    value = 12'(next_random() | 32'h0000_0001);
    scan(1'b0, 12, 64'(value), tdo_bits);
    step(1'b0, 1'b0);
    @(negedge tck);
    check("pre_trst_outputs", 64'(value[10:0]),
          64'({scan_set, scan_rst, scan_cgc, scan_freq_en}));
    @(posedge tck);
    trst_pulse_n <= 1'b0;
    tms          <= 1'b1;
    // No rising edge yet, so the clear is asynchronous
    @(negedge tck);
    check("trst_scan_ctrl_clear", 64'(11'h000),
          64'({scan_set, scan_rst, scan_cgc, scan_freq_en}));
    check("trst_tdo_clear", 64'(1'b0), 64'(tdo));
    @(posedge tck);
    trst_pulse_n <= 1'b1;
    step(1'b0, 1'b0);
    scan(1'b0, 32, 64'(next_random()), tdo_bits);
    check("trst_idcode", 64'(EXP_IDCODE), 64'(tdo_bits[31:0]));
  endtask

  // ----------------------------------------
  // Sequence and watchdog
  // ----------------------------------------
  initial begin
    tms          <= 1'b1;
    tdi          <= 1'b0;
    freeze_n     <= 1'b1;
    highz_n      <= 1'b1;
    iddq_mode    <= 1'b0;
    trst_pulse_n <= 1'b1;
    rng_state    = 32'h3989;
    wait (gen_trst_n === 1'b1);
    step(1'b0, 1'b0);
    test_idcode_after_reset();
    test_bypass();
    test_scan_ctrl();
    test_int_dsr();
    test_unlisted_opcode();
    test_reset_paths();
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin
    repeat (2 * CYCLE_BUDGET) @(posedge tck);
    $display("Watchdog expired: tests did not finish within %0d cycles", 2 * CYCLE_BUDGET);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation timed out");
  end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 5
) (
  output logic o_tck,
  output logic o_trst_n
);

  initial begin
    o_tck = 1'b0;
    forever begin
      #(PERIOD_NS / 2) o_tck = ~o_tck;
    end
  end

  // Reset held low over the first rising edges
  initial begin
    o_trst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge o_tck);
    o_trst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* design/jtag_top.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_top #(
  parameter jtag_pkg::idcode_t IDCODE = jtag_pkg::IDCODE_DEFAULT
) (
  input  logic                 i_tck,
  input  logic                 i_trst_n,
  input  logic                 i_tms,
  input  logic                 i_tdi,
  output logic                 o_tdo,
  input  logic                 i_freeze_n,
  input  logic                 i_highz_n,
  input  logic                 i_iddq_mode,
  output logic                 o_freeze_n,
  output logic                 o_highz_n,
  output logic                 o_iddq_mode,
  output jtag_pkg::scan_freq_t o_scan_freq_en,
  output logic                 o_scan_cgc_ctrl,
  output logic                 o_scan_rst_ctrl,
  output logic                 o_scan_set_ctrl
);

  import jtag_pkg::*;

  tap_strobes_t strobes;
  dr_select_t   dr_select;
  logic         ir_tdo;
  logic         dr_tdo;

  jtag_tap_fsm u_tap_fsm (
    .i_tck     (i_tck),
    .i_trst_n  (i_trst_n),
    .i_tms     (i_tms),
    .o_strobes (strobes)
  );

  jtag_ir_decode u_ir_decode (
    .i_tck     (i_tck),
    .i_trst_n  (i_trst_n),
    .i_tdi     (i_tdi),
    .i_strobes (strobes),
    .o_select  (dr_select),
    .o_ir_tdo  (ir_tdo)
  );

  jtag_data_regs #(
    .IDCODE (IDCODE)
  ) u_data_regs (
    .i_tck           (i_tck),
    .i_trst_n        (i_trst_n),
    .i_tdi           (i_tdi),
    .i_strobes       (strobes),
    .i_select        (dr_select),
    .i_freeze_n      (i_freeze_n),
    .i_highz_n       (i_highz_n),
    .i_iddq_mode     (i_iddq_mode),
    .o_dr_tdo        (dr_tdo),
    .o_scan_freq_en  (o_scan_freq_en),
    .o_scan_cgc_ctrl (o_scan_cgc_ctrl),
    .o_scan_rst_ctrl (o_scan_rst_ctrl),
    .o_scan_set_ctrl (o_scan_set_ctrl),
    .o_freeze_n      (o_freeze_n),
    .o_highz_n       (o_highz_n),
    .o_iddq_mode     (o_iddq_mode)
  );

  jtag_tdo_result u_tdo_result (
    .i_tck     (i_tck),
    .i_trst_n  (i_trst_n),
    .i_strobes (strobes),
    .i_ir_tdo  (ir_tdo),
    .i_dr_tdo  (dr_tdo),
    .o_tdo     (o_tdo)
  );

endmodule

`default_nettype wire

/* design/jtag_tdo_result.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_tdo_result (
  input  logic                   i_tck,
  input  logic                   i_trst_n,
  input  jtag_pkg::tap_strobes_t i_strobes,
  input  logic                   i_ir_tdo,
  input  logic                   i_dr_tdo,
  output logic                   o_tdo
);

  logic tdo_bit;

  // IR bit during Shift-IR, selected DR otherwise
  assign tdo_bit = i_strobes.shift_ir ? i_ir_tdo : i_dr_tdo;

  // ----------------------------------------
  // Falling-edge retime
  // ----------------------------------------
  // Gives the tester half a cycle of setup before the next rising edge
  always_ff @(negedge i_tck or negedge i_trst_n) begin
    if (!i_trst_n) begin
      o_tdo <= 1'b0;
    end else begin
      o_tdo <= tdo_bit;
    end
  end

endmodule

`default_nettype wire

/* design/jtag_data_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_data_regs #(
  parameter jtag_pkg::idcode_t IDCODE = jtag_pkg::IDCODE_DEFAULT
) (
  input  logic                   i_tck,
  input  logic                   i_trst_n,
  input  logic                   i_tdi,
  input  jtag_pkg::tap_strobes_t i_strobes,
  input  jtag_pkg::dr_select_t   i_select,
  input  logic                   i_freeze_n,
  input  logic                   i_highz_n,
  input  logic                   i_iddq_mode,
  output logic                   o_dr_tdo,
  output jtag_pkg::scan_freq_t   o_scan_freq_en,
  output logic                   o_scan_cgc_ctrl,
  output logic                   o_scan_rst_ctrl,
  output logic                   o_scan_set_ctrl,
  output logic                   o_freeze_n,
  output logic                   o_highz_n,
  output logic                   o_iddq_mode
);

  import jtag_pkg::*;

  dr_select_t capture_en;
  dr_select_t shift_en;
  dr_select_t update_en;
  scan_ctrl_t scan_ctrl_q;
  int_dsr_t   int_dsr_q;
  logic       idcode_tdo;
  logic       bypass_tdo;
  logic       scan_ctrl_tdo;
  logic       int_dsr_tdo;
  logic       test_mode;

  // DR strobes reach only the selected register
  assign capture_en = dr_select_t'({4{i_strobes.capture_dr}} & i_select);
  assign shift_en   = dr_select_t'({4{i_strobes.shift_dr}} & i_select);
  assign update_en  = dr_select_t'({4{i_strobes.update_dr}} & i_select);

  jtag_scan_chain #(.WIDTH(IDCODE_WIDTH), .RESET_VAL(IDCODE)) u_idcode (
    .i_tck (i_tck), .i_trst_n (i_trst_n),
    .i_capture (capture_en.sel_idcode), .i_shift (shift_en.sel_idcode),
    .i_update (update_en.sel_idcode),
    .i_pi (IDCODE), .i_tdi (i_tdi), .o_po (), .o_tdo (idcode_tdo)
  );

  // Single bit, captures 0
  jtag_scan_chain #(.WIDTH(1), .RESET_VAL(1'b0)) u_bypass (
    .i_tck (i_tck), .i_trst_n (i_trst_n),
    .i_capture (capture_en.sel_bypass), .i_shift (shift_en.sel_bypass),
    .i_update (update_en.sel_bypass),
    .i_pi (1'b0), .i_tdi (i_tdi), .o_po (), .o_tdo (bypass_tdo)
  );

  // Read back of last written value on capture
  jtag_scan_chain #(.WIDTH(SCAN_CTRL_WIDTH), .RESET_VAL('0)) u_scan_ctrl (
    .i_tck (i_tck), .i_trst_n (i_trst_n),
    .i_capture (capture_en.sel_scan_ctrl), .i_shift (shift_en.sel_scan_ctrl),
    .i_update (update_en.sel_scan_ctrl),
    .i_pi (scan_ctrl_q), .i_tdi (i_tdi), .o_po (scan_ctrl_q), .o_tdo (scan_ctrl_tdo)
  );

  jtag_scan_chain #(.WIDTH(INT_DSR_WIDTH), .RESET_VAL('0)) u_int_dsr (
    .i_tck (i_tck), .i_trst_n (i_trst_n),
    .i_capture (capture_en.sel_int_dsr), .i_shift (shift_en.sel_int_dsr),
    .i_update (update_en.sel_int_dsr),
    .i_pi (int_dsr_q), .i_tdi (i_tdi), .o_po (int_dsr_q), .o_tdo (int_dsr_tdo)
  );

  // ----------------------------------------
  // Chip-side controls
  // ----------------------------------------
  // Bit 11 spare
  assign o_scan_freq_en  = scan_ctrl_q[7:0];
  assign o_scan_cgc_ctrl = scan_ctrl_q[8];
  assign o_scan_rst_ctrl = scan_ctrl_q[9];
  assign o_scan_set_ctrl = scan_ctrl_q[10];

  // Test mode overrides the chip levels
  assign test_mode   = int_dsr_q[0];
  assign o_freeze_n  = test_mode ? ~int_dsr_q[1] : i_freeze_n;
  assign o_highz_n   = test_mode ? ~int_dsr_q[2] : i_highz_n;
  assign o_iddq_mode = test_mode ?  int_dsr_q[3] : i_iddq_mode;

  // Selects are one-hot, bypass as the fallback
  always_comb begin
    if (i_select.sel_idcode) begin
      o_dr_tdo = idcode_tdo;
    end else if (i_select.sel_scan_ctrl) begin
      o_dr_tdo = scan_ctrl_tdo;
    end else if (i_select.sel_int_dsr) begin
      o_dr_tdo = int_dsr_tdo;
    end else begin
      o_dr_tdo = bypass_tdo;
    end
  end

endmodule

`default_nettype wire

/* design/jtag_ir_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_ir_decode (
  input  logic                   i_tck,
  input  logic                   i_trst_n,
  input  logic                   i_tdi,
  input  jtag_pkg::tap_strobes_t i_strobes,
  output jtag_pkg::dr_select_t   o_select,
  output logic                   o_ir_tdo
);

  import jtag_pkg::*;

  // Fixed pattern loaded in Capture-IR, 01 in the two LSBs
  localparam ir_t IR_CAPTURE = 8'h01;

  ir_t ir_q;

  // ----------------------------------------
  // Instruction register
  // ----------------------------------------
  jtag_scan_chain #(
    .WIDTH     (IR_WIDTH),
    .RESET_VAL (INSTR_IDCODE)
  ) u_ir (
    .i_tck     (i_tck),
    .i_trst_n  (i_trst_n),
    .i_capture (i_strobes.capture_ir),
    .i_shift   (i_strobes.shift_ir),
    .i_update  (i_strobes.update_ir),
    .i_pi      (IR_CAPTURE),
    .i_tdi     (i_tdi),
    .o_po      (ir_q),
    .o_tdo     (o_ir_tdo)
  );

  // ----------------------------------------
  // Instruction decode
  // ----------------------------------------
  // Held instruction only changes after Update-IR,
  // so the selects stay stable through a DR scan
  always_comb begin
    o_select = '0;
    case (ir_q)
      INSTR_IDCODE: begin
        o_select.sel_idcode = 1'b1;
      end
      INSTR_SCAN_CTRL: begin
        o_select.sel_scan_ctrl = 1'b1;
      end
      INSTR_INT_DSR: begin
        o_select.sel_int_dsr = 1'b1;
      end
      INSTR_BYPASS: begin
        o_select.sel_bypass = 1'b1;
      end
      // Unknown opcodes fall back to bypass
      default: begin
        o_select.sel_bypass = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/jtag_tap_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_tap_fsm (
  input  logic                  i_tck,
  input  logic                  i_trst_n,
  input  logic                  i_tms,
  output jtag_pkg::tap_strobes_t o_strobes
);

  import jtag_pkg::*;

  tap_state_e state_q;
  tap_state_e state_d;

  always_ff @(posedge i_tck or negedge i_trst_n) begin
    if (!i_trst_n) begin
      state_q <= TAP_TEST_LOGIC_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------
  // Next state from TMS
  // ----------------------------------------
  always_comb begin
    case (state_q)
      TAP_TEST_LOGIC_RESET:
        state_d = i_tms ? TAP_TEST_LOGIC_RESET : TAP_RUN_TEST_IDLE;
      TAP_RUN_TEST_IDLE:
        state_d = i_tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
      TAP_SELECT_DR_SCAN:
        state_d = i_tms ? TAP_SELECT_IR_SCAN : TAP_CAPTURE_DR;
      TAP_CAPTURE_DR:
        state_d = i_tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_SHIFT_DR:
        state_d = i_tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_EXIT1_DR:
        state_d = i_tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
      TAP_PAUSE_DR:
        state_d = i_tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
      TAP_EXIT2_DR:
        state_d = i_tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
      TAP_UPDATE_DR:
        state_d = i_tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
      // Second TMS high from Select-DR heads back to reset
      TAP_SELECT_IR_SCAN:
        state_d = i_tms ? TAP_TEST_LOGIC_RESET : TAP_CAPTURE_IR;
      TAP_CAPTURE_IR:
        state_d = i_tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_SHIFT_IR:
        state_d = i_tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_EXIT1_IR:
        state_d = i_tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
      TAP_PAUSE_IR:
        state_d = i_tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
      TAP_EXIT2_IR:
        state_d = i_tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
      TAP_UPDATE_IR:
        state_d = i_tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
      default:
        state_d = TAP_TEST_LOGIC_RESET;
    endcase
  end

  // ----------------------------------------
  // State strobes
  // ----------------------------------------
  always_comb begin
    o_strobes = '0;
    case (state_q)
      TAP_CAPTURE_DR: o_strobes.capture_dr = 1'b1;
      TAP_SHIFT_DR:   o_strobes.shift_dr   = 1'b1;
      TAP_UPDATE_DR:  o_strobes.update_dr  = 1'b1;
      TAP_CAPTURE_IR: o_strobes.capture_ir = 1'b1;
      TAP_SHIFT_IR:   o_strobes.shift_ir   = 1'b1;
      TAP_UPDATE_IR:  o_strobes.update_ir  = 1'b1;
      default:        o_strobes = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/jtag_scan_chain.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_scan_chain #(
  parameter int               WIDTH     = 8,
  parameter logic [WIDTH-1:0] RESET_VAL = '0
) (
  input  logic             i_tck,
  input  logic             i_trst_n,
  input  logic             i_capture,
  input  logic             i_shift,
  input  logic             i_update,
  input  logic [WIDTH-1:0] i_pi,
  input  logic             i_tdi,
  output logic [WIDTH-1:0] o_po,
  output logic             o_tdo
);

  logic [WIDTH-1:0] shift_q;
  logic [WIDTH-1:0] shift_next;
  logic [WIDTH-1:0] update_q;

  // TDI enters at the MSB, everything moves one toward bit 0
  assign shift_next = WIDTH'({i_tdi, shift_q} >> 1);

  // ----------------------------------------
  // Shift stage
  // ----------------------------------------
  always_ff @(posedge i_tck or negedge i_trst_n) begin
    if (!i_trst_n) begin
      shift_q <= RESET_VAL;
    end else if (i_capture) begin
      shift_q <= i_pi;
    end else if (i_shift) begin
      shift_q <= shift_next;
    end
  end

  // ----------------------------------------
  // Update stage
  // ----------------------------------------
  always_ff @(posedge i_tck or negedge i_trst_n) begin
    if (!i_trst_n) begin
      update_q <= RESET_VAL;
    end else if (i_update) begin
      update_q <= shift_q;
    end
  end

  assign o_po  = update_q;

  // LSB first on the serial side
  assign o_tdo = shift_q[0];

endmodule

`default_nettype wire

/* design/jtag_pkg.sv */
`default_nettype none

package jtag_pkg;

  // ----------------------------------------
  // Register lengths
  // ----------------------------------------
  localparam int IR_WIDTH        = 8;
  localparam int IDCODE_WIDTH    = 32;
  localparam int SCAN_CTRL_WIDTH = 12;
  localparam int INT_DSR_WIDTH   = 4;

  typedef logic [IR_WIDTH-1:0]        ir_t;
  typedef logic [IDCODE_WIDTH-1:0]    idcode_t;
  typedef logic [SCAN_CTRL_WIDTH-1:0] scan_ctrl_t;

  // Bit 0 test mode, 1 freeze, 2 high-z, 3 IDDQ
  typedef logic [INT_DSR_WIDTH-1:0]   int_dsr_t;

  // Scan frequency enables, low byte of SCAN_CTRL
  typedef logic [7:0]                 scan_freq_t;

  // ----------------------------------------
  // Instruction codes
  // ----------------------------------------
  localparam ir_t INSTR_BYPASS    = 8'hFF;
  localparam ir_t INSTR_IDCODE    = 8'h15;
  localparam ir_t INSTR_SCAN_CTRL = 8'h39;
  localparam ir_t INSTR_INT_DSR   = 8'h40;

  // LSB must stay set per IEEE 1149.1
  localparam idcode_t IDCODE_DEFAULT = 32'h7761_7601;

  // TAP controller states
  typedef enum logic [3:0] {
    TAP_EXIT2_DR         = 4'h0,
    TAP_EXIT1_DR         = 4'h1,
    TAP_SHIFT_DR         = 4'h2,
    TAP_PAUSE_DR         = 4'h3,
    TAP_SELECT_IR_SCAN   = 4'h4,
    TAP_UPDATE_DR        = 4'h5,
    TAP_CAPTURE_DR       = 4'h6,
    TAP_SELECT_DR_SCAN   = 4'h7,
    TAP_EXIT2_IR         = 4'h8,
    TAP_EXIT1_IR         = 4'h9,
    TAP_SHIFT_IR         = 4'hA,
    TAP_PAUSE_IR         = 4'hB,
    TAP_RUN_TEST_IDLE    = 4'hC,
    TAP_UPDATE_IR        = 4'hD,
    TAP_CAPTURE_IR       = 4'hE,
    TAP_TEST_LOGIC_RESET = 4'hF
  } tap_state_e;

  // One strobe per active TAP state
  typedef struct packed {
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
  } tap_strobes_t;

  // One-hot data register select
  typedef struct packed {
    logic sel_bypass;
    logic sel_idcode;
    logic sel_scan_ctrl;
    logic sel_int_dsr;
  } dr_select_t;

endpackage

`default_nettype wire
